//--- sim.f
logic/bp_pkg.sv
logic/branch_target_buffer.sv
logic/global_history_predictor.sv
logic/perf_counter.sv
logic/branch_resolver.sv
logic/fetch_pc.sv
logic/branch_predictor.sv
testbench/tb_branch_predictor.sv

//--- Makefile
# Verilator build of the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_branch_predictor.sv
module tb_branch_predictor;
    import bp_pkg::*;

    localparam int fix = 0;
    localparam int rnd = 1;
    localparam int prev_pc = 2;     // res_pc of the last valid row
    localparam int tag_none = 0;
    localparam int tag_model = 1;   // tag as the model would have fetched it

    localparam logic [3:0] chk_pc = 4'b0001;
    localparam logic [3:0] chk_redirect = 4'b0010;
    localparam logic [3:0] chk_pred = 4'b0100;
    localparam logic [3:0] chk_count = 4'b1000;
    localparam logic [3:0] chk_all = 4'b1111;

    typedef struct {
        int                       grp;
        logic                     stl;
        logic                     vld;
        cf_kind_t                 kind;
        logic                     tkn;
        int                       pc_src;
        logic [xlen-1:0]          pc_val;
        int                       tgt_src;
        logic [xlen-1:0]          tgt_val;
        int                       tag;
        logic [history_depth-1:0] ghist;
        logic [3:0]               chk;
    } row_t;

    logic                           clk;
    logic                           rst;
    logic                           stall;
    logic                           res_valid;
    logic [xlen-1:0]                res_pc;
    cf_kind_t                       res_kind;
    logic                           res_taken;
    logic [xlen-1:0]                res_target;
    logic                           res_hit;
    logic                           res_pred_taken;
    logic [xlen-1:0]                res_pred_target;
    logic [history_depth-1:0]       res_ghist;
    logic [xlen-1:0]                pc;
    logic                           pred_hit;
    logic                           pred_taken;
    logic [xlen-1:0]                pred_target;
    logic [history_depth-1:0]       pred_ghist;
    logic                           redirect;
    logic [perf_counter_width-1:0]  num_control_flow;
    logic [perf_counter_width-1:0]  num_correct;

    // reference model state
    logic                           m_valid [btb_entries];
    logic [btb_tag_bits-1:0]        m_tag [btb_entries];
    cf_kind_t                       m_kind [btb_entries];
    logic [xlen-1:0]                m_target [btb_entries];
    logic [1:0]                     m_ctr [pht_entries];
    logic [history_depth-1:0]       m_hist;
    logic [xlen-1:0]                m_pc;
    logic [perf_counter_width-1:0]  m_ncf;
    logic [perf_counter_width-1:0]  m_ncor;
    logic [xlen-1:0]                last_pc;

    // outcome of the resolve driven this cycle
    logic                           r_accept;
    logic                           r_redirect;
    logic                           r_correct;
    logic [xlen-1:0]                r_atgt;
    logic [xlen-1:0]                r_next;

    row_t        rows [$];
    logic [31:0] lfsr_state = 32'd70266;
    int          checks = 0;
    int          errors = 0;
    int          grp_errors = 0;
    int          grp_rows = 0;
    int          tests = 0;
    int          cycles = 0;
    int          cycle_limit = 1000000;

    branch_predictor i_dut (
        .clk              (clk),
        .rst              (rst),
        .stall            (stall),
        .res_valid        (res_valid),
        .res_pc           (res_pc),
        .res_kind         (res_kind),
        .res_taken        (res_taken),
        .res_target       (res_target),
        .res_hit          (res_hit),
        .res_pred_taken   (res_pred_taken),
        .res_pred_target  (res_pred_target),
        .res_ghist        (res_ghist),
        .pc               (pc),
        .pred_hit         (pred_hit),
        .pred_taken       (pred_taken),
        .pred_target      (pred_target),
        .pred_ghist       (pred_ghist),
        .redirect         (redirect),
        .num_control_flow (num_control_flow),
        .num_correct      (num_correct)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: table not finished after %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};     // one step per bit
        end
    endtask

    function automatic string test_name(input int grp);
        case (grp)
            1:       return "reset, sequential fetch and stall";
            2:       return "taken branch missing in the buffer";
            3:       return "jal and jalr target training";
            4:       return "counter training and global history";
            default: return "matching prediction tag and stalled resolve";
        endcase
    endfunction

    function automatic logic model_hit(input logic [xlen-1:0] a);
        return m_valid[a[5:2]] && (m_tag[a[5:2]] == a[31:6]);
    endfunction

    function automatic logic model_taken(input logic [xlen-1:0] a);
        cf_kind_t k;
        k = m_kind[a[5:2]];
        if (!model_hit(a)) begin
            return 1'b0;
        end
        return (k == jal) || (k == jalr) || (k == br && m_ctr[m_hist][1]);
    endfunction

    task automatic add_row(input int grp, input logic stl, input logic vld, input cf_kind_t kind,
                           input logic tkn, input int pc_src, input logic [xlen-1:0] pc_val,
                           input int tgt_src, input logic [xlen-1:0] tgt_val, input int tag,
                           input logic [history_depth-1:0] ghist, input logic [3:0] chk);
        rows.push_back('{grp, stl, vld, kind, tkn, pc_src, pc_val, tgt_src, tgt_val, tag,
                         ghist, chk});
    endtask

    task automatic resolve_row(input int grp, input logic stl, input cf_kind_t kind,
                               input logic tkn, input int pc_src, input logic [xlen-1:0] pc_val,
                               input int tgt_src, input logic [xlen-1:0] tgt_val, input int tag,
                               input logic [history_depth-1:0] ghist);
        add_row(grp, stl, 1'b1, kind, tkn, pc_src, pc_val, tgt_src, tgt_val, tag, ghist, chk_all);
    endtask

    task automatic idle_rows(input int grp, input logic stl, input int n, input logic [3:0] chk);
        for (int i = 0; i < n; i++) begin
            add_row(grp, stl, 1'b0, none, 1'b0, fix, 32'h0, fix, 32'h0, tag_none, 6'd0, chk);
        end
    endtask

    task automatic build_table();
        idle_rows(1, 1'b0, 4, chk_all);
        idle_rows(1, 1'b1, 3, chk_pc | chk_count);
        idle_rows(1, 1'b0, 2, chk_all);
        resolve_row(2, 1'b0, br, 1'b1, fix, 32'h40, fix, 32'h100, tag_none, 6'd0);
        idle_rows(2, 1'b0, 2, chk_all);
        resolve_row(2, 1'b0, br, 1'b1, rnd, 32'h0, rnd, 32'h0, tag_none, 6'd0);
        idle_rows(2, 1'b0, 1, chk_all);
        resolve_row(3, 1'b0, jal, 1'b1, fix, 32'h88, fix, 32'h300, tag_none, 6'd0);
        resolve_row(3, 1'b0, br, 1'b1, fix, 32'h50, prev_pc, 32'h0, tag_none, 6'd10);
        idle_rows(3, 1'b0, 2, chk_all);
        resolve_row(3, 1'b0, jalr, 1'b1, fix, 32'hc4, fix, 32'h401, tag_none, 6'd0);
        resolve_row(3, 1'b0, jal, 1'b1, fix, 32'h60, prev_pc, 32'h0, tag_none, 6'd0);
        idle_rows(3, 1'b0, 2, chk_all);
        resolve_row(3, 1'b0, jal, 1'b1, rnd, 32'h0, rnd, 32'h0, tag_none, 6'd0);
        resolve_row(3, 1'b0, br, 1'b1, fix, 32'h40, prev_pc, 32'h0, tag_none, 6'd1);
        idle_rows(3, 1'b0, 2, chk_all);
        // counter 62 is the history seen when 0x90 is fetched next
        for (int i = 0; i < 3; i++) begin
            resolve_row(4, 1'b0, br, 1'b1, fix, 32'h90, fix, 32'h200, tag_none, 6'd62);
        end
        resolve_row(4, 1'b0, br, 1'b0, fix, 32'h90, fix, 32'h200, tag_none, 6'd62);
        resolve_row(4, 1'b0, jal, 1'b1, fix, 32'ha0, fix, 32'h90, tag_none, 6'd0);
        idle_rows(4, 1'b0, 3, chk_all);
        resolve_row(4, 1'b0, br, 1'b0, fix, 32'h94, fix, 32'h200, tag_none, 6'd63);
        resolve_row(4, 1'b0, br, 1'b1, fix, 32'h98, rnd, 32'h0, tag_none, 6'd7);
        resolve_row(4, 1'b0, br, 1'b1, fix, 32'h90, fix, 32'h200, tag_none, 6'd5);
        resolve_row(4, 1'b0, jal, 1'b1, fix, 32'ha0, fix, 32'h90, tag_none, 6'd0);
        idle_rows(4, 1'b0, 3, chk_all);
        resolve_row(5, 1'b0, jal, 1'b1, fix, 32'h88, fix, 32'h300, tag_model, 6'd0);
        resolve_row(5, 1'b0, br, 1'b1, fix, 32'h90, fix, 32'h200, tag_model, 6'd0);
        resolve_row(5, 1'b0, br, 1'b0, fix, 32'h90, fix, 32'h200, tag_model, 6'd0);
        resolve_row(5, 1'b1, jal, 1'b1, fix, 32'h500, fix, 32'h700, tag_none, 6'd0);
        resolve_row(5, 1'b1, br, 1'b1, fix, 32'h88, fix, 32'h40, tag_none, 6'd3);
        idle_rows(5, 1'b0, 1, chk_all);
        resolve_row(5, 1'b0, jalr, 1'b1, fix, 32'hc4, fix, 32'h401, tag_model, 6'd0);
        idle_rows(5, 1'b0, 2, chk_all);
    endtask

    task automatic reset_model();
        for (int i = 0; i < btb_entries; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i] = '0;
            m_kind[i] = none;
            m_target[i] = '0;
        end
        for (int i = 0; i < pht_entries; i++) begin
            m_ctr[i] = 2'd1;    // weakly not-taken
        end
        m_hist = '0;
        m_pc = reset_pc;
        m_ncf = '0;
        m_ncor = '0;
        last_pc = '0;
    endtask

    task automatic drive_row(input row_t row);
        logic [31:0]     bits;
        logic [xlen-1:0] a;
        logic [xlen-1:0] t;
        case (row.pc_src)
            rnd: begin
                take_bits(30, bits);
                a = {bits[29:0], 2'b00} | 32'h4;    // odd buffer index
            end
            prev_pc: a = last_pc;
            default: a = row.pc_val;
        endcase
        case (row.tgt_src)
            rnd: begin
                take_bits(30, bits);
                t = {bits[29:0], 2'b00};
                if (row.kind == jalr) begin
                    t[0] = 1'b1;
                end
            end
            prev_pc: t = last_pc;
            default: t = row.tgt_val;
        endcase
        stall = row.stl;
        res_valid = row.vld;
        res_kind = row.kind;
        res_taken = row.tkn;
        res_pc = a;
        res_target = t;
        if (row.tag == tag_model) begin
            res_hit = model_hit(a);
            res_pred_taken = model_taken(a);
            res_pred_target = model_hit(a) ? m_target[a[5:2]] : '0;
            res_ghist = m_hist;
        end else begin
            res_hit = 1'b0;
            res_pred_taken = 1'b0;
            res_pred_target = '0;
            res_ghist = row.ghist;
        end
        if (row.vld) begin
            last_pc = a;
        end
    endtask

    task automatic judge_resolve();
        logic [xlen-1:0] seq;
        logic [xlen-1:0] pred_next;
        seq = res_pc + 32'd4;
        r_accept = res_valid && !stall;
        r_atgt = (res_kind == jalr) ? {res_target[xlen-1:1], 1'b0} : res_target;
        r_next = res_taken ? r_atgt : seq;
        pred_next = res_pred_taken ? res_pred_target : seq;
        r_redirect = r_accept && (r_next != pred_next);
        case (res_kind)
            br: begin
                if (res_hit) begin
                    r_correct = (res_pred_taken == res_taken) && (res_pred_target == r_atgt);
                end else begin
                    r_correct = !res_taken;
                end
            end
            jal, jalr: r_correct = res_hit && (res_pred_target == r_atgt);
            default:   r_correct = 1'b0;
        endcase
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            grp_errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_outputs(input logic [3:0] chk);
        logic hit;
        logic taken;
        hit = model_hit(m_pc);
        taken = model_taken(m_pc);
        if ((chk & chk_pc) != 4'b0000) begin
            check("pc", pc, m_pc);
        end
        if ((chk & chk_redirect) != 4'b0000) begin
            check("redirect", 32'(redirect), 32'(r_redirect));
        end
        if ((chk & chk_pred) != 4'b0000) begin
            check("pred_hit", 32'(pred_hit), 32'(hit));
            check("pred_taken", 32'(pred_taken), 32'(taken));
            check("pred_ghist", 32'(pred_ghist), 32'(m_hist));
            if (hit) begin
                check("pred_target", pred_target, m_target[m_pc[5:2]]);
            end
        end
        if ((chk & chk_count) != 4'b0000) begin
            check("num_control_flow", 32'(num_control_flow), 32'(m_ncf));
            check("num_correct", 32'(num_correct), 32'(m_ncor));
        end
    endtask

    task automatic advance_model();
        logic [xlen-1:0] nxt;
        logic [3:0]      w;
        if (stall) begin
            nxt = m_pc;
        end else if (r_redirect) begin
            nxt = r_next;
        end else if (model_taken(m_pc)) begin
            nxt = m_target[m_pc[5:2]];
        end else begin
            nxt = m_pc + 32'd4;
        end
        if (r_accept) begin
            if (res_kind == br) begin
                if (res_taken && m_ctr[res_ghist] != 2'd3) begin
                    m_ctr[res_ghist] = m_ctr[res_ghist] + 2'd1;
                end else if (!res_taken && m_ctr[res_ghist] != 2'd0) begin
                    m_ctr[res_ghist] = m_ctr[res_ghist] - 2'd1;
                end
                m_hist = {m_hist[history_depth-2:0], res_taken};
            end
            if (res_kind == jal || res_kind == jalr || (res_kind == br && res_taken)) begin
                w = res_pc[5:2];
                m_valid[w] = 1'b1;
                m_tag[w] = res_pc[31:6];
                m_kind[w] = res_kind;
                m_target[w] = r_atgt;
            end
            if (res_kind != none) begin
                m_ncf = m_ncf + 16'd1;
            end
            if (r_correct) begin
                m_ncor = m_ncor + 16'd1;
            end
        end
        m_pc = nxt;
    endtask

    task automatic report_test(input int grp);
        tests++;
        $display("test %0d (%s): %0d rows, %0d mismatches", grp, test_name(grp), grp_rows,
                 grp_errors);
        grp_rows = 0;
        grp_errors = 0;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        res_valid = 1'b0;
        res_pc = '0;
        res_kind = none;
        res_taken = 1'b0;
        res_target = '0;
        res_hit = 1'b0;
        res_pred_taken = 1'b0;
        res_pred_target = '0;
        res_ghist = '0;
        reset_model();
        build_table();
        cycle_limit = 16 + 4 * rows.size() + 50;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < rows.size(); r++) begin
            drive_row(rows[r]);
            judge_resolve();
            #1;                 // outputs settled, posedge still ahead
            compare_outputs(rows[r].chk);
            advance_model();
            grp_rows++;
            if (r == rows.size() - 1 || rows[r + 1].grp != rows[r].grp) begin
                report_test(rows[r].grp);
            end
            @(negedge clk);
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_branch_predictor

//--- logic/branch_predictor.sv
module branch_predictor (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    stall,

    // resolved instruction from decode
    input  logic                                    res_valid,
    input  logic [bp_pkg::xlen-1:0]                 res_pc,
    input  bp_pkg::cf_kind_t                        res_kind,
    input  logic                                    res_taken,
    input  logic [bp_pkg::xlen-1:0]                 res_target,
    input  logic                                    res_hit,
    input  logic                                    res_pred_taken,
    input  logic [bp_pkg::xlen-1:0]                 res_pred_target,
    input  logic [bp_pkg::history_depth-1:0]        res_ghist,

    // fetch address and its prediction tag
    output logic [bp_pkg::xlen-1:0]                 pc,
    output logic                                    pred_hit,
    output logic                                    pred_taken,
    output logic [bp_pkg::xlen-1:0]                 pred_target,
    output logic [bp_pkg::history_depth-1:0]        pred_ghist,
    output logic                                    redirect,

    output logic [bp_pkg::perf_counter_width-1:0]   num_control_flow,
    output logic [bp_pkg::perf_counter_width-1:0]   num_correct
);
    import bp_pkg::*;

    btb_entry_t      lookup_entry;
    btb_entry_t      btb_wr_entry;
    logic            btb_write;
    logic [xlen-1:0] redirect_pc;
    logic            train_dir;
    logic            count_cf;
    logic            count_correct;

    assign pred_target = lookup_entry.target;

    branch_target_buffer i_btb (
        .clk      (clk),
        .rst      (rst),
        .rd_pc    (pc),
        .wr_en    (btb_write),
        .wr_pc    (res_pc),
        .wr_entry (btb_wr_entry),
        .rd_hit   (pred_hit),
        .rd_entry (lookup_entry)
    );

    global_history_predictor i_ghp (
        .clk         (clk),
        .rst         (rst),
        .train       (train_dir),
        .train_taken (res_taken),
        .train_index (res_ghist),   // counter that made the prediction
        .lookup_hit  (pred_hit),
        .lookup_kind (lookup_entry.kind),
        .history     (pred_ghist),
        .pred_taken  (pred_taken)
    );

    branch_resolver i_resolver (
        .stall           (stall),
        .res_valid       (res_valid),
        .res_pc          (res_pc),
        .res_target      (res_target),
        .res_pred_target (res_pred_target),
        .res_kind        (res_kind),
        .res_taken       (res_taken),
        .res_hit         (res_hit),
        .res_pred_taken  (res_pred_taken),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .train_dir       (train_dir),
        .btb_write       (btb_write),
        .btb_wr_entry    (btb_wr_entry),
        .count_cf        (count_cf),
        .count_correct   (count_correct)
    );

    fetch_pc i_fetch_pc (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pred_taken  (pred_taken),
        .pred_target (lookup_entry.target),
        .pc          (pc)
    );

    perf_counter #(.width(perf_counter_width)) i_cf_counter (
        .clk   (clk),
        .rst   (rst),
        .count (count_cf),
        .value (num_control_flow)
    );

    perf_counter #(.width(perf_counter_width)) i_correct_counter (
        .clk   (clk),
        .rst   (rst),
        .count (count_correct),
        .value (num_correct)
    );

endmodule : branch_predictor

//--- logic/fetch_pc.sv
module fetch_pc (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     redirect,
    input  logic [bp_pkg::xlen-1:0]  redirect_pc,
    input  logic                     pred_taken,
    input  logic [bp_pkg::xlen-1:0]  pred_target,
    output logic [bp_pkg::xlen-1:0]  pc
);
    import bp_pkg::*;

    logic [xlen-1:0] next_pc;

    // a redirect beats the prediction for this cycle
    always_comb begin
        if (stall) begin
            next_pc = pc;
        end else if (redirect) begin
            next_pc = redirect_pc;
        end else if (pred_taken) begin
            next_pc = pred_target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

    // targets from the buffer and from decode must keep fetch aligned
    pc_aligned: assert property (
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
    );

endmodule : fetch_pc

//--- logic/branch_resolver.sv
module branch_resolver (
    input  logic                     stall,
    input  logic                     res_valid,
    input  logic [bp_pkg::xlen-1:0]  res_pc,
    input  logic [bp_pkg::xlen-1:0]  res_target,
    input  logic [bp_pkg::xlen-1:0]  res_pred_target,
    input  bp_pkg::cf_kind_t         res_kind,
    input  logic                     res_taken,
    input  logic                     res_hit,
    input  logic                     res_pred_taken,
    output logic                     redirect,
    output logic [bp_pkg::xlen-1:0]  redirect_pc,
    output logic                     train_dir,
    output logic                     btb_write,
    output bp_pkg::btb_entry_t       btb_wr_entry,
    output logic                     count_cf,
    output logic                     count_correct
);
    import bp_pkg::*;

    logic            accept;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] actual_target;
    logic [xlen-1:0] actual_next;
    logic [xlen-1:0] pred_next;
    logic            target_ok;
    logic            correct;

    assign accept = res_valid && !stall;
    assign seq_pc = res_pc + 32'd4;

    // jalr drops the low bit of rs1 + imm
    assign actual_target = (res_kind == jalr) ? {res_target[xlen-1:1], 1'b0} : res_target;
    assign actual_next   = res_taken ? actual_target : seq_pc;
    assign pred_next     = res_pred_taken ? res_pred_target : seq_pc;

    assign redirect    = accept && (actual_next != pred_next);
    assign redirect_pc = actual_next;

    assign target_ok = (res_pred_target == actual_target);

    // direction and target both count toward a correct prediction
    always_comb begin
        correct = 1'b0;
        unique case (res_kind)
            br: begin
                if (res_hit) begin
                    correct = (res_pred_taken == res_taken) && target_ok;
                end else begin
                    correct = !res_taken;   // a miss falls through
                end
            end
            jal, jalr: correct = res_hit && target_ok;
            default:   correct = 1'b0;
        endcase
    end

    assign count_cf      = accept && (res_kind != none);
    assign count_correct = accept && correct;

    assign train_dir = accept && (res_kind == br);
    assign btb_write = accept && ((res_kind == jal) || (res_kind == jalr) ||
                                  (res_kind == br && res_taken));

    assign btb_wr_entry = '{
        valid:  1'b1,
        tag:    res_pc[xlen-1:btb_index_bits+2],
        kind:   res_kind,
        target: actual_target
    };

endmodule : branch_resolver

//--- logic/perf_counter.sv
module perf_counter #(
    parameter int width = bp_pkg::perf_counter_width
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             count,
    output logic [width-1:0] value
);

    // wraps to zero past the top, no overflow flag
    always_ff @(posedge clk) begin
        if (rst) begin
            value <= '0;
        end else if (count) begin
            value <= value + 1'b1;
        end
    end

endmodule : perf_counter

//--- logic/global_history_predictor.sv
module global_history_predictor (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              train,
    input  logic                              train_taken,
    input  logic [bp_pkg::history_depth-1:0]  train_index,
    input  logic                              lookup_hit,
    input  bp_pkg::cf_kind_t                  lookup_kind,
    output logic [bp_pkg::history_depth-1:0]  history,
    output logic                              pred_taken
);
    import bp_pkg::*;

    counter_t pht [pht_entries];    // indexed by global history
    counter_t train_ctr;
    logic     dir_taken;

    assign train_ctr = pht[train_index];
    assign dir_taken = pht[history][1];     // upper bit gives direction

    // jumps always go, branches follow the counter
    always_comb begin
        pred_taken = 1'b0;
        if (lookup_hit) begin
            unique case (lookup_kind)
                jal, jalr: pred_taken = 1'b1;
                br:        pred_taken = dir_taken;
                default:   pred_taken = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            history <= '0;
        end else if (train) begin
            history <= {history[history_depth-2:0], train_taken};   // newest outcome at bit 0
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pht_entries; i++) begin
                pht[i] <= weak_nt;
            end
        end else if (train) begin
            if (train_taken && train_ctr != strong_t) begin
                pht[train_index] <= counter_t'(train_ctr + 2'd1);
            end else if (!train_taken && train_ctr != strong_nt) begin
                pht[train_index] <= counter_t'(train_ctr - 2'd1);
            end
        end
    end

    // counter moves only toward the outcome, so it never wraps
    ctr_saturates: assert property (
        @(posedge clk) disable iff (rst)
        train |=> ($past(train_taken) ? (pht[$past(train_index)] >= $past(train_ctr))
                                      : (pht[$past(train_index)] <= $past(train_ctr)))
    );

endmodule : global_history_predictor

//--- logic/branch_target_buffer.sv
module branch_target_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bp_pkg::xlen-1:0]  rd_pc,
    input  logic                     wr_en,
    input  logic [bp_pkg::xlen-1:0]  wr_pc,
    input  bp_pkg::btb_entry_t       wr_entry,
    output logic                     rd_hit,
    output bp_pkg::btb_entry_t       rd_entry
);
    import bp_pkg::*;

    logic [btb_index_bits-1:0] rd_index;
    logic [btb_tag_bits-1:0]   rd_tag;
    logic [btb_index_bits-1:0] wr_index;
    logic [btb_tag_bits-1:0]   wr_tag;

    logic [btb_entries-1:0] valid;      // one valid bit per entry
    btb_entry_t             entries [btb_entries];

    // word aligned, so bits 1:0 never take part
    assign rd_index = rd_pc[btb_index_bits+1:2];
    assign rd_tag   = rd_pc[xlen-1:btb_index_bits+2];
    assign wr_index = wr_pc[btb_index_bits+1:2];
    assign wr_tag   = wr_pc[xlen-1:btb_index_bits+2];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;
        end
    end

    // payload, tag always taken from the write address
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_index] <= '{
                valid:  1'b1,
                tag:    wr_tag,
                kind:   wr_entry.kind,
                target: wr_entry.target
            };
        end
    end

    // asynchronous lookup for the fetch pc
    always_comb begin
        rd_entry       = entries[rd_index];
        rd_entry.valid = valid[rd_index];   // stored copy may be stale before first write
        rd_hit         = valid[rd_index] && (entries[rd_index].tag == rd_tag);
    end

    wr_en_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(wr_en)
    );

endmodule : branch_target_buffer

//--- logic/bp_pkg.sv
package bp_pkg;

    // address and table geometry
    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = '0;

    localparam int btb_index_bits = 4;                          // pc[5:2]
    localparam int btb_entries = 1 << btb_index_bits;
    localparam int btb_tag_bits = xlen - btb_index_bits - 2;    // pc bits above the index

    localparam int history_depth = 6;
    localparam int pht_entries = 1 << history_depth;            // one counter per history value

    localparam int perf_counter_width = 16;

    // kind of control-flow instruction, as reported by decode
    typedef enum logic [1:0] {
        none = 2'b00,
        br   = 2'b01,
        jal  = 2'b10,
        jalr = 2'b11
    } cf_kind_t;

    // two-bit saturating counter, upper bit is the predicted direction
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } counter_t;

    typedef struct packed {
        logic                    valid;
        logic [btb_tag_bits-1:0] tag;
        cf_kind_t                kind;
        logic [xlen-1:0]         target;
    } btb_entry_t;

endpackage : bp_pkg
